// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert -j 0
TOP       ?= tb_pred_ras
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# exit status of the model is the pass or fail result
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== design/pred_call_ret_decode.sv ====
// Call and return decode, stage 1 of the return address predictor
// Decodes every halfword of a fetch block as a compressed and as a
// standard candidate, masks by lane enables and valid, picks the
// lowest call and forms its return address. Purely combinational.

`timescale 1ns/1ps

module pred_call_ret_decode (
  input  logic                              i_resp_valid,
  input  logic [pred_pkg::FETCH_W-1:0]      i_resp_data,
  input  logic [pred_pkg::FETCH_HW-1:0]     i_resp_be,
  input  logic [pred_pkg::VADDR_W-1:1]      i_resp_vaddr,
  output logic                              o_push,
  output logic [pred_pkg::FETCH_HW-1:0]     o_call_be,
  output logic [pred_pkg::FETCH_HW-1:0]     o_ret_be,
  output logic                              o_ret_any,
  output logic [pred_pkg::VADDR_W-1:1]      o_push_addr
);

  logic [pred_pkg::FETCH_HW-1:0] w_rvc_call;
  logic [pred_pkg::FETCH_HW-1:0] w_std_call;
  logic [pred_pkg::FETCH_HW-1:0] w_ret_hit;
  logic [pred_pkg::FETCH_HW-1:0] w_lane_en;
  logic [pred_pkg::HW_IDX_W-1:0] w_call_off;
  logic                          w_call_std;
  logic [1:0]                    w_call_size;
  logic [pred_pkg::VADDR_W-1:1]  w_blk_base;

  // ----------------------------------------
  // per halfword decode
  // ----------------------------------------
  for (genvar g = 0; g < pred_pkg::FETCH_HW; g++) begin : g_lane
    logic [pred_pkg::HW_W-1:0] w_rvc_inst;
    logic                      w_rvc_jal;
    logic                      w_rvc_jalr;
    logic                      w_rvc_ret;

    assign w_rvc_inst = i_resp_data[g*pred_pkg::HW_W +: pred_pkg::HW_W];

    // c.jal, quadrant 1, funct3 001
    assign w_rvc_jal = pred_pkg::RVC_JAL_EN &
                       (w_rvc_inst[1:0] == 2'b01) &
                       (w_rvc_inst[15:13] == 3'b001);
    // c.jalr: rs1 nonzero, rs2 zero
    assign w_rvc_jalr = (w_rvc_inst[1:0] == 2'b10) &
                        (w_rvc_inst[15:12] == 4'b1001) &
                        (w_rvc_inst[11:7] != 5'd0) &
                        (w_rvc_inst[6:2] == 5'd0);
    assign w_rvc_call[g] = w_rvc_jal | w_rvc_jalr;
    assign w_rvc_ret = (w_rvc_inst == pred_pkg::RVC_RET);

    if (g < pred_pkg::FETCH_HW - 1) begin : g_std
      logic [2*pred_pkg::HW_W-1:0] w_std_inst;
      logic                        w_std_jal;
      logic                        w_std_jalr;

      assign w_std_inst = i_resp_data[g*pred_pkg::HW_W +: 2*pred_pkg::HW_W];
      // jal ra or jalr ra
      assign w_std_jal = (w_std_inst[6:0] == pred_pkg::OPC_JAL) &
                         (w_std_inst[11:7] == pred_pkg::RA_REG);
      assign w_std_jalr = (w_std_inst[6:0] == pred_pkg::OPC_JALR) &
                          (w_std_inst[14:12] == 3'b000) &
                          (w_std_inst[11:7] == pred_pkg::RA_REG);
      assign w_std_call[g] = w_std_jal | w_std_jalr;
      assign w_ret_hit[g] = w_rvc_ret | (w_std_inst == pred_pkg::STD_RET);
    end else begin : g_edge
      // would cross the block edge, not decoded as standard
      assign w_std_call[g] = 1'b0;
      assign w_ret_hit[g] = w_rvc_ret;
    end
  end

  // ----------------------------------------
  // masking and call select
  // ----------------------------------------
  assign w_lane_en = i_resp_be & {pred_pkg::FETCH_HW{i_resp_valid}};

  // a standard call also covers the halfword after it
  assign o_call_be = (w_rvc_call | w_std_call |
                      {w_std_call[pred_pkg::FETCH_HW-2:0], 1'b0}) & w_lane_en;
  assign o_ret_be = w_ret_hit & w_lane_en;
  assign o_ret_any = |o_ret_be;
  assign o_push = |o_call_be;

  // lowest set call bit wins
  always_comb begin
    w_call_off = '0;
    for (int i = pred_pkg::FETCH_HW - 1; i >= 0; i--) begin
      if (o_call_be[i]) begin
        w_call_off = i[pred_pkg::HW_IDX_W-1:0];
      end
    end
  end

  assign w_call_std = w_std_call[w_call_off];
  // return lands one or two halfwords past the call
  assign w_call_size = w_call_std ? 2'd2 : 2'd1;

  // halfword address of the block start
  assign w_blk_base = {i_resp_vaddr[pred_pkg::VADDR_W-1:pred_pkg::HW_IDX_W+1],
                       {pred_pkg::HW_IDX_W{1'b0}}};

  assign o_push_addr = w_blk_base +
                       {{(pred_pkg::VADDR_W-1-pred_pkg::HW_IDX_W){1'b0}}, w_call_off} +
                       {{(pred_pkg::VADDR_W-3){1'b0}}, w_call_size};

endmodule

// ==== design/pred_pkg.sv ====
// Return address predictor package
// Fetch block geometry, address width, stack depth and the
// instruction encodings that the call and return decode matches.

package pred_pkg;

  // ----------------------------------------
  // fetch block geometry
  // ----------------------------------------
  // halfwords per fetch block
  localparam int FETCH_HW = 8;
  // bits per halfword
  localparam int HW_W = 16;
  // data bits per block
  localparam int FETCH_W = FETCH_HW * HW_W;
  // halfword offset inside a block
  localparam int HW_IDX_W = $clog2(FETCH_HW);

  // virtual address width, addresses travel as bits VADDR_W-1:1
  localparam int VADDR_W = 32;

  // ----------------------------------------
  // return address stack
  // ----------------------------------------
  localparam int RAS_DEPTH = 8;
  // index wraps modulo RAS_DEPTH
  localparam int RAS_IDX_W = $clog2(RAS_DEPTH);

  // ----------------------------------------
  // decode encodings
  // ----------------------------------------
  // c.jal exists on RV32 only
  localparam bit RVC_JAL_EN = 1'b1;

  // link register x1
  localparam logic [4:0] RA_REG = 5'd1;

  localparam logic [6:0] OPC_JAL = 7'b1101111;
  localparam logic [6:0] OPC_JALR = 7'b1100111;

  // c.jr ra and jalr x0, 0(x1)
  localparam logic [15:0] RVC_RET = 16'h8082;
  localparam logic [31:0] STD_RET = 32'h00008067;

endpackage

// ==== design/pred_ras.sv ====
// Return address stack storage
// RAS_DEPTH halfword addresses. Writes land at the clock edge; the
// read of the top is registered together with its valid bit. A read
// and write to one entry in the same cycle returns the old contents.

`timescale 1ns/1ps

module pred_ras (
  input  logic                            i_clk,
  input  logic                            i_reset_n,
  input  logic                            i_wr_valid,
  input  logic [pred_pkg::RAS_IDX_W-1:0]  i_wr_index,
  input  logic [pred_pkg::VADDR_W-1:1]    i_wr_addr,
  input  logic                            i_rd_valid,
  input  logic [pred_pkg::RAS_IDX_W-1:0]  i_rd_index,
  output logic                            o_rd_valid,
  output logic [pred_pkg::VADDR_W-1:1]    o_rd_addr
);

  logic [pred_pkg::VADDR_W-1:1] r_stack [pred_pkg::RAS_DEPTH];
  logic                         r_rd_valid;
  logic [pred_pkg::VADDR_W-1:1] r_rd_addr;

  // ----------------------------------------
  // storage
  // ----------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_wr_valid) begin
      r_stack[i_wr_index] <= i_wr_addr;
    end
  end

  // ----------------------------------------
  // registered read of the top
  // ----------------------------------------
  // address only follows real reads
  always_ff @(posedge i_clk) begin
    if (i_rd_valid) begin
      r_rd_addr <= r_stack[i_rd_index];
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rd_valid <= 1'b0;
    end else begin
      r_rd_valid <= i_rd_valid;
    end
  end

  assign o_rd_valid = r_rd_valid;
  assign o_rd_addr = r_rd_addr;

endmodule

// ==== design/pred_ras_index.sv ====
// Speculative return address stack index
// Follows fetch by one per pushing block. A call commit overrides the
// base: a live group loads the committed index, an all-dead group
// rolls back to the restore index. Also keeps the last live
// committed call index.

`timescale 1ns/1ps

module pred_ras_index (
  input  logic                            i_clk,
  input  logic                            i_reset_n,
  input  logic                            i_push,
  input  logic                            i_cmt_valid,
  input  logic                            i_cmt_is_call,
  input  logic                            i_cmt_all_dead,
  input  logic [pred_pkg::RAS_IDX_W-1:0]  i_cmt_ras_index,
  input  logic [pred_pkg::RAS_IDX_W-1:0]  i_cmt_restore_index,
  output logic [pred_pkg::RAS_IDX_W-1:0]  o_wr_index,
  output logic [pred_pkg::RAS_IDX_W-1:0]  o_rd_index,
  output logic [pred_pkg::RAS_IDX_W-1:0]  o_cmt_ras_index
);

  logic                           w_cmt_live;
  logic                           w_cmt_dead;
  logic [pred_pkg::RAS_IDX_W-1:0] w_base;
  logic [pred_pkg::RAS_IDX_W-1:0] w_next;
  logic [pred_pkg::RAS_IDX_W-1:0] r_index;
  logic [pred_pkg::RAS_IDX_W-1:0] r_cmt_index;

  assign w_cmt_live = i_cmt_valid & i_cmt_is_call & ~i_cmt_all_dead;
  assign w_cmt_dead = i_cmt_valid & i_cmt_is_call & i_cmt_all_dead;

  // commit correction ahead of this block's push
  always_comb begin
    w_base = r_index;
    if (w_cmt_live) begin
      w_base = i_cmt_ras_index;
    end else if (w_cmt_dead) begin
      // younger group dead, roll back
      w_base = i_cmt_restore_index;
    end
  end

  // wraps modulo RAS_DEPTH
  assign w_next = w_base + {{(pred_pkg::RAS_IDX_W-1){1'b0}}, i_push};

  assign o_wr_index = w_next;
  // read sees the top before the push
  assign o_rd_index = w_base;
  assign o_cmt_ras_index = r_cmt_index;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_index <= '0;
      r_cmt_index <= '0;
    end else begin
      r_index <= w_next;
      if (w_cmt_live) begin
        r_cmt_index <= i_cmt_ras_index;
      end
    end
  end

endmodule

// ==== design/pred_ras_top.sv ====
// Return address predictor top level
// Two stage pipeline: call and return decode in stage 1, index update
// and stack access in stage 2. All outputs are registered, one cycle
// after the fetch response.

`timescale 1ns/1ps

module pred_ras_top (
  input  logic                            i_clk,
  input  logic                            i_reset_n,
  // fetch response
  input  logic                            i_resp_valid,
  input  logic [pred_pkg::FETCH_W-1:0]    i_resp_data,
  input  logic [pred_pkg::FETCH_HW-1:0]   i_resp_be,
  input  logic [pred_pkg::VADDR_W-1:1]    i_resp_vaddr,
  // commit
  input  logic                            i_cmt_valid,
  input  logic                            i_cmt_is_call,
  input  logic                            i_cmt_all_dead,
  input  logic [pred_pkg::RAS_IDX_W-1:0]  i_cmt_ras_index,
  input  logic [pred_pkg::RAS_IDX_W-1:0]  i_cmt_restore_index,
  // prediction
  output logic [pred_pkg::FETCH_HW-1:0]   o_call_be,
  output logic [pred_pkg::FETCH_HW-1:0]   o_ret_be,
  output logic                            o_ret_valid,
  output logic [pred_pkg::VADDR_W-1:1]    o_ret_vaddr,
  output logic [pred_pkg::RAS_IDX_W-1:0]  o_ras_index,
  output logic [pred_pkg::RAS_IDX_W-1:0]  o_cmt_ras_index
);

  logic                           w_push;
  logic [pred_pkg::FETCH_HW-1:0]  w_call_be;
  logic [pred_pkg::FETCH_HW-1:0]  w_ret_be;
  logic                           w_ret_any;
  logic [pred_pkg::VADDR_W-1:1]   w_push_addr;
  logic [pred_pkg::RAS_IDX_W-1:0] w_wr_index;
  logic [pred_pkg::RAS_IDX_W-1:0] w_rd_index;
  logic [pred_pkg::FETCH_HW-1:0]  r_call_be;
  logic [pred_pkg::FETCH_HW-1:0]  r_ret_be;
  logic [pred_pkg::RAS_IDX_W-1:0] r_ras_index;

  // ----------------------------------------
  // stage 1, decode
  // ----------------------------------------
  pred_call_ret_decode u_decode (
    .i_resp_valid (i_resp_valid),
    .i_resp_data  (i_resp_data),
    .i_resp_be    (i_resp_be),
    .i_resp_vaddr (i_resp_vaddr),
    .o_push       (w_push),
    .o_call_be    (w_call_be),
    .o_ret_be     (w_ret_be),
    .o_ret_any    (w_ret_any),
    .o_push_addr  (w_push_addr)
  );

  // ----------------------------------------
  // stage 2, index and stack
  // ----------------------------------------
  pred_ras_index u_index (
    .i_clk               (i_clk),
    .i_reset_n           (i_reset_n),
    .i_push              (w_push),
    .i_cmt_valid         (i_cmt_valid),
    .i_cmt_is_call       (i_cmt_is_call),
    .i_cmt_all_dead      (i_cmt_all_dead),
    .i_cmt_ras_index     (i_cmt_ras_index),
    .i_cmt_restore_index (i_cmt_restore_index),
    .o_wr_index          (w_wr_index),
    .o_rd_index          (w_rd_index),
    .o_cmt_ras_index     (o_cmt_ras_index)
  );

  // push to the next index, read the pre-push top
  pred_ras u_ras (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_wr_valid (w_push),
    .i_wr_index (w_wr_index),
    .i_wr_addr  (w_push_addr),
    .i_rd_valid (w_ret_any),
    .i_rd_index (w_rd_index),
    .o_rd_valid (o_ret_valid),
    .o_rd_addr  (o_ret_vaddr)
  );

  // flags and index line up with the stack read
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_call_be <= '0;
      r_ret_be <= '0;
      r_ras_index <= '0;
    end else begin
      r_call_be <= w_call_be;
      r_ret_be <= w_ret_be;
      r_ras_index <= w_wr_index;
    end
  end

  assign o_call_be = r_call_be;
  assign o_ret_be = r_ret_be;
  assign o_ras_index = r_ras_index;

endmodule

// ==== src.f ====
design/pred_pkg.sv
design/pred_call_ret_decode.sv
design/pred_ras_index.sv
design/pred_ras.sv
design/pred_ras_top.sv
tests/pred_ras_chk.sv
tests/tb_pred_ras.sv

// ==== tests/pred_ras_chk.sv ====
// Return address predictor assertions
// Bound to the top level, watches the registered flag outputs
// around reset and idle fetch cycles.

`timescale 1ns/1ps

module pred_ras_chk (
  input logic                          i_clk,
  input logic                          i_reset_n,
  input logic                          i_resp_valid,
  input logic                          o_ret_valid,
  input logic [pred_pkg::FETCH_HW-1:0] o_call_be,
  input logic [pred_pkg::FETCH_HW-1:0] o_ret_be
);

  // no prediction while in reset
  a_ret_valid_in_reset : assert property (
    @(posedge i_clk) !i_reset_n |-> !o_ret_valid
  ) else $error("o_ret_valid high during reset");

  // a predicted return has a return lane
  a_ret_valid_has_lane : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    o_ret_valid |-> (o_ret_be != '0)
  ) else $error("o_ret_valid without any o_ret_be lane");

  // idle fetch cycle gives empty masks next cycle
  a_idle_clears_flags : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    !i_resp_valid |=> ((o_call_be == '0) && (o_ret_be == '0))
  ) else $error("flags set after an idle fetch cycle");

endmodule

// ==== tests/pred_ras_input.txt ====
// valid be vaddr | h0 h1 h2 h3 h4 h5 h6 h7 | cmt_valid is_call all_dead ras_idx restore_idx
// expected call_be ret_be, all hex
1 FF 00001000  9282 0001 0001 0001 0001 0001 0001 0001  0 0 0 0 0  01 00
1 FF 00001000  0001 0001 0001 8082 0001 0001 0001 0001  0 0 0 0 0  00 08
1 FF 00002000  0001 0001 00EF 0000 0001 0001 0001 0001  0 0 0 0 0  0C 00
1 FF 00003000  0001 9282 0001 0001 0001 8067 0000 0001  0 0 0 0 0  02 20
1 FF 00004010  0001 0001 0001 0001 80E7 0002 2001 0001  0 0 0 0 0  70 00
1 FF 00005000  0001 0001 0001 0001 0001 0001 0001 8082  0 0 0 0 0  00 80
1 FD 00005000  8082 9282 0001 02EF 0000 0001 0001 0001  0 0 0 0 0  00 01
0 FF 00005000  9282 0001 8082 0001 0001 0001 0001 0001  0 0 0 0 0  00 00
1 FF 00005000  006F 0000 0001 9002 0001 0001 0001 0001  0 0 0 0 0  00 00
1 FF 00005000  0001 0001 0001 0001 0001 0001 0001 0001  1 1 0 6 2  00 00
1 FF 00006000  0001 0001 0001 0001 0001 0001 0001 9282  1 1 1 5 3  80 00
1 FF 00006000  0001 0001 8067 0000 0001 0001 0001 0001  0 0 0 0 0  00 04
1 FF 00006000  0001 0001 0001 0001 0001 0001 0001 0001  1 0 0 1 1  00 00
1 FF 00007000  00EF 0000 0001 0001 0001 0001 0001 0001  1 1 0 7 0  03 00
1 FF 00007000  0001 0001 0001 0001 8082 0001 0001 0001  0 0 0 0 0  00 10
1 FF 00008000  0001 8082 0001 0001 0001 2001 0001 0001  0 0 0 0 0  20 02
1 FF 00009000  0001 0001 0001 0001 0001 0001 80E7 0002  0 0 0 0 0  C0 00
1 FF 00009000  8067 0000 0001 0001 0001 0001 0001 0001  0 0 0 0 0  00 01
1 FF 0000A000  0001 0001 0001 9082 0001 0001 0001 0001  0 0 0 0 0  08 00
1 FF 0000A000  0001 0001 0001 0001 0001 8082 0001 0001  1 1 1 6 1  00 20
1 FF 0000B000  0001 0001 9282 0001 0001 0001 0001 0001  0 0 0 0 0  04 00
1 FF 0000C000  0001 00EF 0000 0001 0001 0001 0001 0001  0 0 0 0 0  06 00
1 FF 0000C000  0001 0001 0001 0001 0001 0001 8082 0001  0 0 0 0 0  00 40
1 FF 0000C000  8067 0000 0001 0001 0001 0001 0001 0001  1 1 0 2 4  00 01
1 EF 0000C000  0001 0001 0001 0001 8082 0001 0001 8082  0 0 0 0 0  00 80
0 FF 0000D000  9282 0001 0001 0001 0001 0001 0001 0001  1 1 0 5 0  00 00

// ==== tests/tb_pred_ras.sv ====
// Return address predictor testbench
// Reads fetch blocks and commits from a vector file, runs a stack and
// index model alongside the DUT, then adds random non-control blocks.

`timescale 1ns/1ps

module tb_pred_ras;

  localparam int NUM_VEC = 26;
  localparam int VEC_WORDS = 18;
  localparam int NUM_FILL = 8;
  localparam int RESET_CYCLES = 16;
  localparam int SEED = 9142;
  localparam int CYCLE_LIMIT = NUM_VEC + NUM_FILL + RESET_CYCLES + 20;

  logic                            i_clk;
  logic                            i_reset_n;
  logic                            i_resp_valid;
  logic [pred_pkg::FETCH_W-1:0]    i_resp_data;
  logic [pred_pkg::FETCH_HW-1:0]   i_resp_be;
  logic [pred_pkg::VADDR_W-1:1]    i_resp_vaddr;
  logic                            i_cmt_valid;
  logic                            i_cmt_is_call;
  logic                            i_cmt_all_dead;
  logic [pred_pkg::RAS_IDX_W-1:0]  i_cmt_ras_index;
  logic [pred_pkg::RAS_IDX_W-1:0]  i_cmt_restore_index;
  logic [pred_pkg::FETCH_HW-1:0]   o_call_be;
  logic [pred_pkg::FETCH_HW-1:0]   o_ret_be;
  logic                            o_ret_valid;
  logic [pred_pkg::VADDR_W-1:1]    o_ret_vaddr;
  logic [pred_pkg::RAS_IDX_W-1:0]  o_ras_index;
  logic [pred_pkg::RAS_IDX_W-1:0]  o_cmt_ras_index;

  logic [31:0] vec_mem [NUM_VEC*VEC_WORDS];
  // reference stack and index
  logic [pred_pkg::VADDR_W-1:1]    m_stack [pred_pkg::RAS_DEPTH];
  logic [pred_pkg::RAS_DEPTH-1:0]  m_written;
  logic [pred_pkg::RAS_IDX_W-1:0]  m_index;
  logic [pred_pkg::RAS_IDX_W-1:0]  m_cmt_index;
  int cycle_count;
  int error_count;
  int vec_num;

  pred_ras_top u_pred_ras_top (.*);

  bind pred_ras_top pred_ras_chk u_chk (.*);

  always #50 i_clk = ~i_clk;

  // ----------------------------------------
  // run limit
  // ----------------------------------------
  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("run exceeded %0d cycles without finishing", CYCLE_LIMIT);
      $display("Checks failed");
      $fatal(1, "timeout");
    end
  end

  task automatic abort_run(input string why);
    error_count++;
    $display("%s (vector %0d)", why, vec_num);
    $display("Checks failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_be(input string name, input logic [pred_pkg::FETCH_HW-1:0] got,
                          input logic [pred_pkg::FETCH_HW-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input logic [pred_pkg::VADDR_W-1:1] got,
                            input logic [pred_pkg::VADDR_W-1:1] exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_index(input string name, input logic [pred_pkg::RAS_IDX_W-1:0] got,
                             input logic [pred_pkg::RAS_IDX_W-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch %s got %h expected %h", name, got, exp));
    end
  endtask

  // ----------------------------------------
  // one block: drive, model, check a cycle later
  // ----------------------------------------
  task automatic run_block(
    input logic valid, input logic [pred_pkg::FETCH_HW-1:0] be, input logic [31:0] vaddr,
    input logic [pred_pkg::FETCH_W-1:0] data, input logic cv, input logic ic,
    input logic ad, input logic [pred_pkg::RAS_IDX_W-1:0] cri,
    input logic [pred_pkg::RAS_IDX_W-1:0] crs,
    input logic [pred_pkg::FETCH_HW-1:0] exp_call, input logic [pred_pkg::FETCH_HW-1:0] exp_ret);
    logic [pred_pkg::RAS_IDX_W-1:0] base;
    logic [pred_pkg::RAS_IDX_W-1:0] next;
    logic [pred_pkg::VADDR_W-1:1]   exp_addr;
    int off;
    int size;
    i_resp_valid = valid;
    i_resp_be = be;
    i_resp_vaddr = vaddr[31:1];
    i_resp_data = data;
    i_cmt_valid = cv;
    i_cmt_is_call = ic;
    i_cmt_all_dead = ad;
    i_cmt_ras_index = cri;
    i_cmt_restore_index = crs;
    // commit picks the base before this block's push
    base = m_index;
    if (cv && ic) begin
      base = ad ? crs : cri;
    end
    next = base;
    exp_addr = '0;
    if (exp_ret != '0) begin
      if (!m_written[base]) begin
        abort_run("vector reads a stack entry that was never written");
      end
      exp_addr = m_stack[base];
    end
    if (exp_call != '0) begin
      off = 0;
      while (!exp_call[off]) off++;
      // low bits 11 mark a 32-bit instruction
      size = (data[off*16 +: 2] == 2'b11) ? 2 : 1;
      next = base + {{(pred_pkg::RAS_IDX_W-1){1'b0}}, 1'b1};
      m_stack[next] = {vaddr[31:4], 3'b000} + 31'(off) + 31'(size);
      m_written[next] = 1'b1;
    end
    if (cv && ic && !ad) begin
      m_cmt_index = cri;
    end
    m_index = next;
    @(posedge i_clk);
    #1;
    check_be("o_call_be", o_call_be, exp_call);
    check_be("o_ret_be", o_ret_be, exp_ret);
    check_flag("o_ret_valid", o_ret_valid, exp_ret != '0);
    if (exp_ret != '0) begin
      check_addr("o_ret_vaddr", o_ret_vaddr, exp_addr);
    end
    check_index("o_ras_index", o_ras_index, next);
    check_index("o_cmt_ras_index", o_cmt_ras_index, m_cmt_index);
    #4;
  endtask

  initial begin
    int b;
    int seed_value;
    logic [pred_pkg::FETCH_W-1:0] data;
    seed_value = $urandom(SEED);
    i_clk = 1'b0;
    i_reset_n = 1'b0;
    i_resp_valid = 1'b0;
    i_resp_data = '0;
    i_resp_be = '0;
    i_resp_vaddr = '0;
    i_cmt_valid = 1'b0;
    i_cmt_is_call = 1'b0;
    i_cmt_all_dead = 1'b0;
    i_cmt_ras_index = '0;
    i_cmt_restore_index = '0;
    m_written = '0;
    m_index = '0;
    m_cmt_index = '0;
    error_count = 0;
    vec_num = 0;
    $readmemh("tests/pred_ras_input.txt", vec_mem);
    repeat (RESET_CYCLES) @(posedge i_clk);
    #5;
    i_reset_n = 1'b1;
    for (int k = 0; k < NUM_VEC; k++) begin
      vec_num = k;
      b = k * VEC_WORDS;
      for (int h = 0; h < pred_pkg::FETCH_HW; h++) begin
        data[h*16 +: 16] = vec_mem[b+3+h][15:0];
      end
      run_block(vec_mem[b][0], vec_mem[b+1][7:0], vec_mem[b+2], data,
                vec_mem[b+11][0], vec_mem[b+12][0], vec_mem[b+13][0],
                vec_mem[b+14][2:0], vec_mem[b+15][2:0],
                vec_mem[b+16][7:0], vec_mem[b+17][7:0]);
    end
    // filler: c.addi style halfwords, never a call or return
    for (int k = 0; k < NUM_FILL; k++) begin
      vec_num = NUM_VEC + k;
      for (int h = 0; h < pred_pkg::FETCH_HW; h++) begin
        data[h*16 +: 16] = {3'b000, 11'($urandom), 2'b01};
      end
      run_block(1'b1, 8'hFF, $urandom, data, 1'b0, 1'b0, 1'b0, '0, '0, '0, '0);
    end
    if (error_count == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("Checks failed");
      $fatal(1, "errors recorded");
    end
  end

endmodule
